//--- files.f
+incdir+source
source/mem_pkg.sv
source/audio_pkg.sv
source/audio_regs.sv
source/sample_ram.sv
source/audio_mixer.sv
source/audio_dac.sv
source/audio_top.sv
sim/tb_clock_gen.sv
sim/tb_audio_top.sv

//--- Bender.yml
package:
  name: audio_playback

sources:
  - include_dirs:
      - source
    files:
      - source/mem_pkg.sv
      - source/audio_pkg.sv
      - source/audio_regs.sv
      - source/sample_ram.sv
      - source/audio_mixer.sv
      - source/audio_dac.sv
      - source/audio_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - sim/tb_clock_gen.sv
      - sim/tb_audio_top.sv

//--- sim/tb_audio_top.sv
// testbench for the audio subsystem with a case table, density counting and typed compares
`include "audio_settings.svh"

module tb_audio_top;
    timeunit 1ns;
    timeprecision 1ps;

    import mem_pkg::*;
    import audio_pkg::*;

    localparam int WINDOW       = 2 ** `AUDIO_DAC_WIDTH;   // one full accumulator cycle
    localparam int RELOAD_LIMIT = 1000;
    localparam int RESET_LIMIT  = 100;
    localparam int RUN_LIMIT    = 50000;

    typedef struct packed {
        logic  enable;
        word_t vol;
        word_t period;
        word_t len;                 // length word without the restart bit
        byte_t sample;              // constant sample byte in every memory byte
        byte_t exp_l;
        byte_t exp_r;
    } row_t;

    logic       clk;
    logic       reset;
    logic       enable;
    logic       dma_start;
    logic       reg_wr;
    audio_reg_e reg_addr;
    word_t      reg_data;
    word_t      reg_rdata;
    logic       ram_wr;
    addr_t      ram_addr;
    word_t      ram_data;
    logic       reload;
    logic       pdm_l;
    logic       pdm_r;

    row_t       rows [$];
    int         seed;
    int         checks;

    tb_clock_gen #(
        .PERIOD_NS    (40),
        .RESET_CYCLES (8)
    ) u_clock (
        .clk_o   (clk),
        .reset_o (reset)
    );

    audio_top DUT (
        .clk         (clk),
        .reset_i     (reset),
        .enable_i    (enable),
        .dma_start_i (dma_start),
        .reg_wr_i    (reg_wr),
        .reg_addr_i  (reg_addr),
        .reg_data_i  (reg_data),
        .reg_rdata_o (reg_rdata),
        .ram_wr_i    (ram_wr),
        .ram_addr_i  (ram_addr),
        .ram_data_i  (ram_data),
        .reload_o    (reload),
        .pdm_l_o     (pdm_l),
        .pdm_r_o     (pdm_r)
    );

    task automatic report_failure();
        $display("** FAIL **");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_level(input string what, input byte_t got, input byte_t exp);
        checks++;
        if (got !== exp) begin
            $display("ERROR at %0t: %s got %h, expected %h", $time, what, got, exp);
            report_failure();
        end
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            $display("ERROR at %0t: %s got %h, expected %h", $time, what, got, exp);
            report_failure();
        end
    endtask

    task automatic check_pulse(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("ERROR at %0t: %s got %b, expected %b", $time, what, got, exp);
            report_failure();
        end
    endtask

    function automatic void add_case(input logic en, input word_t vol, input word_t period,
                                     input word_t len, input byte_t sample,
                                     input byte_t exp_l, input byte_t exp_r);
        rows.push_back({en, vol, period, len, sample, exp_l, exp_r});
    endfunction

    // level = {~p[13], p[12:6]} with p = sample * (vol >> 1), no wrap for |sample| <= 64
    function automatic void build_table();
        add_case(1'b0, 16'h3CA5, 16'h0010, 16'h0003, 8'h11, 8'h3C, 8'hA5);  // raw volume
        add_case(1'b0, 16'hF00F, 16'h0020, 16'h0005, 8'h22, 8'hF0, 8'h0F);
        add_case(1'b1, 16'hFEFE, 16'h0007, 16'h0004, 8'h40, 8'hFF, 8'hFF);  // 64*127 = 8128
        add_case(1'b1, 16'h8040, 16'h0009, 16'h0002, 8'hC0, 8'h40, 8'h60);  // -64*64, -64*32
        add_case(1'b1, 16'h00C8, 16'h000B, 16'h0001, 8'h20, 8'h80, 8'hB2);  // pan, 32*100
        add_case(1'b1, 16'h2A7F, 16'h0007, 16'h0020, 8'hD3, 8'h71, 8'h53);  // -45*21, -45*63
        add_case(1'b0, 16'h8000, 16'h0005, 16'h0002, 8'h00, 8'h80, 8'h00);
        add_case(1'b1, 16'h4444, 16'h000F, 16'h0003, 8'h7F, 8'hC3, 8'hC3);  // 127*34 = 4318
    endfunction

    // all tasks below start and end on a falling edge
    task automatic write_reg(input audio_reg_e addr, input word_t data);
        reg_addr = addr;
        reg_data = data;
        reg_wr   = 1'b1;
        @(negedge clk);
        reg_wr   = 1'b0;
    endtask

    task automatic read_reg(input audio_reg_e addr, output word_t data);
        reg_addr = addr;
        #1;                                     // readback is combinational
        data = reg_rdata;
        @(negedge clk);
    endtask

    // every word gets the sample twice, random base and upper bits test truncation
    task automatic fill_ram(input byte_t sample);
        int base;
        int upper;
        base  = $random(seed) & 32'hFF;
        upper = $random(seed) & 32'hFF;
        for (int i = 0; i < `SAMPLE_RAM_WORDS; i++) begin
            ram_addr = addr_t'(upper * `SAMPLE_RAM_WORDS + (base + i) % `SAMPLE_RAM_WORDS);
            ram_data = {sample, sample};
            ram_wr   = 1'b1;
            @(negedge clk);
        end
        ram_wr = 1'b0;
    endtask

    task automatic wait_reload(input int limit);
        int cycles;
        cycles = 0;
        while (reload !== 1'b1 && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (reload !== 1'b1) begin
            $display("no reload pulse seen within %0d cycles after setting the restart bit",
                     limit);
            report_failure();
        end
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    // worst case: old period runs out, stale word drains, then the multiply lag
    function automatic int settle_cycles(input word_t period);
        return 4 * (int'(period[14:0]) + 1) + 32;
    endfunction

    task automatic count_window(output int ones_l, output int ones_r, output int pulses);
        ones_l = 0;
        ones_r = 0;
        pulses = 0;
        for (int i = 0; i < WINDOW; i++) begin
            @(negedge clk);
            ones_l += int'(pdm_l);
            ones_r += int'(pdm_r);
            pulses += int'(reload);
        end
    endtask

    // DMA pacing, one pulse every fourth cycle
    initial begin : dma_pacing
        int phase;
        dma_start = 1'b0;
        phase     = 0;
        forever begin
            @(negedge clk);
            dma_start = (phase == 0) && !reset;
            phase     = (phase + 1) % 4;
        end
    end

    initial begin : watchdog
        repeat (RUN_LIMIT) @(posedge clk);
        $display("simulation ran past its limit of %0d cycles", RUN_LIMIT);
        report_failure();
    end

    initial begin : main
        row_t  r;
        word_t rd;
        addr_t start;
        int    ones_l;
        int    ones_r;
        int    pulses;
        int    cycles;
        enable   = 1'b0;
        reg_wr   = 1'b0;
        reg_addr = AUD_VOL;
        reg_data = '0;
        ram_wr   = 1'b0;
        ram_addr = '0;
        ram_data = '0;
        seed     = 82;
        checks   = 0;
        build_table();

        cycles = 0;
        @(negedge clk);
        while (reset !== 1'b0 && cycles < RESET_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (reset !== 1'b0) begin
            $display("reset was not released within %0d cycles", RESET_LIMIT);
            report_failure();
        end

        foreach (rows[k]) begin
            r      = rows[k];
            start  = addr_t'($random(seed));
            enable = r.enable;
            fill_ram(r.sample);
            write_reg(AUD_VOL, r.vol);
            write_reg(AUD_PERIOD, r.period);
            write_reg(AUD_START, start);
            write_reg(AUD_LEN, r.enable ? (r.len | 16'h8000) : r.len);
            if (r.enable) begin
                wait_reload(RELOAD_LIMIT);
            end
            read_reg(AUD_VOL, rd);
            check_word("AUD_VOL readback", rd, r.vol);
            read_reg(AUD_PERIOD, rd);
            check_word("AUD_PERIOD readback", rd, r.period);
            read_reg(AUD_START, rd);
            check_word("AUD_START readback", rd, start);
            read_reg(AUD_LEN, rd);                  // restart bit gone, length kept
            check_word("AUD_LEN readback", rd, r.len);

            idle(settle_cycles(r.period));
            count_window(ones_l, ones_r, pulses);
            check_level("left pulse density", byte_t'(ones_l), r.exp_l);
            check_level("right pulse density", byte_t'(ones_r), r.exp_r);
            if (!r.enable) begin
                check_pulse("reload seen while disabled", pulses != 0, 1'b0);
            end else if (r.len < 16'd8) begin
                check_pulse("reload during short-length playback", pulses > 0, 1'b1);
            end
        end

        $display("%0d checks over %0d cases", checks, rows.size());
        $display("** PASS **");
        $finish;
    end

endmodule

//--- sim/tb_clock_gen.sv
// testbench clock and synchronous reset source
module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 8
) (
    output logic clk_o,
    output logic reset_o
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);                       // release away from the active edge
        reset_o = 1'b0;
    end

endmodule

//--- source/audio_top.sv
// audio subsystem top with registers, sample memory, mixer and two DACs
`include "audio_settings.svh"

module audio_top (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  enable_i,
    input  logic                  dma_start_i,
    input  logic                  reg_wr_i,
    input  audio_pkg::audio_reg_e reg_addr_i,
    input  mem_pkg::word_t        reg_data_i,
    output mem_pkg::word_t        reg_rdata_o,
    input  logic                  ram_wr_i,
    input  mem_pkg::addr_t        ram_addr_i,
    input  mem_pkg::word_t        ram_data_i,
    output logic                  reload_o,
    output logic                  pdm_l_o,
    output logic                  pdm_r_o
);
    import mem_pkg::*;
    import audio_pkg::*;

    logic       audio_enable;
    audio_vol_t vol;
    word_t      period;
    addr_t      start;
    audio_len_u len;
    addr_t      fetch_addr;
    word_t      fetch_word;
    byte_t      level_l;
    byte_t      level_r;

    audio_regs u_regs (
        .clk            (clk),
        .reset_i        (reset_i),
        .enable_i       (enable_i),
        .reg_wr_i       (reg_wr_i),
        .reg_addr_i     (reg_addr_i),
        .reg_data_i     (reg_data_i),
        .reg_rdata_o    (reg_rdata_o),
        .reload_i       (reload_o),
        .audio_enable_o (audio_enable),
        .vol_o          (vol),
        .period_o       (period),
        .start_o        (start),
        .len_o          (len)
    );

    sample_ram u_ram (
        .clk       (clk),
        .wr_i      (ram_wr_i),
        .wr_addr_i (ram_addr_i),
        .wr_data_i (ram_data_i),
        .rd_addr_i (fetch_addr),
        .rd_data_o (fetch_word)
    );

    // the memory reads every cycle, so fetch only paces the mixer itself
    audio_mixer u_mixer (
        .clk            (clk),
        .reset_i        (reset_i),
        .audio_enable_i (audio_enable),
        .dma_start_i    (dma_start_i),
        .vol_i          (vol),
        .period_i       (period),
        .start_i        (start),
        .len_i          (len),
        .reload_o       (reload_o),
        .fetch_o        (),
        .addr_o         (fetch_addr),
        .word_i         (fetch_word),
        .level_l_o      (level_l),
        .level_r_o      (level_r)
    );

    audio_dac #(
        .WIDTH (`AUDIO_DAC_WIDTH)
    ) u_dac_l (
        .clk     (clk),
        .reset_i (reset_i),
        .value_i (level_l),
        .pulse_o (pdm_l_o)
    );

    audio_dac #(
        .WIDTH (`AUDIO_DAC_WIDTH)
    ) u_dac_r (
        .clk     (clk),
        .reset_i (reset_i),
        .value_i (level_r),
        .pulse_o (pdm_r_o)
    );

endmodule

//--- source/audio_dac.sv
// first-order sigma-delta pulse-density modulator
`include "audio_settings.svh"

module audio_dac #(
    parameter int WIDTH = `AUDIO_DAC_WIDTH
) (
    input  logic             clk,
    input  logic             reset_i,
    input  logic [WIDTH-1:0] value_i,
    output logic             pulse_o
);
    logic [WIDTH-1:0] acc_q;
    logic [WIDTH:0]   sum;
    logic             pulse_q;

    assign sum = {1'b0, acc_q} + {1'b0, value_i};   // carry is the density bit

    always_ff @(posedge clk) begin
        if (reset_i) begin
            acc_q   <= '0;
            pulse_q <= 1'b0;
        end else begin
            acc_q   <= sum[WIDTH-1:0];
            pulse_q <= sum[WIDTH];
        end
    end

    assign pulse_o = pulse_q;

endmodule

//--- source/audio_mixer.sv
// channel fetch, sample sequencing, two-phase volume multiply and DAC levels
module audio_mixer (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  audio_enable_i,
    input  logic                  dma_start_i,
    input  audio_pkg::audio_vol_t vol_i,
    input  mem_pkg::word_t        period_i,
    input  mem_pkg::addr_t        start_i,
    input  audio_pkg::audio_len_u len_i,
    output logic                  reload_o,
    output logic                  fetch_o,
    output mem_pkg::addr_t        addr_o,
    input  mem_pkg::word_t        word_i,
    output mem_pkg::byte_t        level_l_o,
    output mem_pkg::byte_t        level_r_o
);
    import mem_pkg::*;

    typedef enum logic {
        MIX_LOAD  = 1'b0,       // latch sample and volumes
        MIX_STORE = 1'b1        // take the products as new levels
    } mix_state_e;

    logic               fetch_q;
    logic               reload_q;
    logic               second_q;       // next sendout takes the low byte
    addr_t              addr_q;
    word_t              length_q;       // bit 15 is the underflow flag
    word_t              length_n;
    word_t              period_q;       // bit 15 set means sendout
    logic               sendout;
    logic               capture;
    logic               need_reload;
    word_t              word0_q;        // prefetched word
    word_t              word1_q;        // word being shifted out
    logic               word0_ok;
    logic               word1_ok;
    logic signed [7:0]  sample_q;

    mix_state_e         mix_state;
    logic signed [7:0]  mul_sample_q;
    logic signed [7:0]  mul_vol_l_q;
    logic signed [7:0]  mul_vol_r_q;
    logic signed [15:0] prod_l;
    logic signed [15:0] prod_r;
    byte_t              level_l_q;
    byte_t              level_r_q;

    assign sendout     = period_q[15];
    assign length_n    = length_q - 16'd1;
    assign need_reload = length_n[15] || len_i.f.restart;
    // fetch holds the address so the word on word_i matches addr_q here
    assign capture     = fetch_q && second_q && audio_enable_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            fetch_q  <= 1'b0;
            reload_q <= 1'b0;
            second_q <= 1'b0;
            addr_q   <= '0;
            length_q <= '0;             // forces a reload on the first fetch
            period_q <= '1;             // immediate first sendout
            word0_q  <= '0;
            word1_q  <= '0;
            word0_ok <= 1'b0;
            word1_ok <= 1'b0;
            sample_q <= '0;
        end else begin
            reload_q <= 1'b0;

            // period+1 cycles between sendouts
            if (sendout) begin
                period_q <= {1'b0, period_i[14:0]} - 16'd1;
            end else begin
                period_q <= period_q - 16'd1;
            end

            if (capture) begin
                fetch_q  <= 1'b0;
                word0_q  <= word_i;
                word0_ok <= 1'b1;
                if (need_reload) begin
                    addr_q   <= start_i;
                    length_q <= {1'b0, len_i.f.length};
                    reload_q <= 1'b1;
                end else begin
                    addr_q   <= addr_q + 16'd1;
                    length_q <= length_n;
                end
            end else if (dma_start_i && audio_enable_i && !word0_ok) begin
                fetch_q <= 1'b1;        // pacing pulse only fills an empty buffer
            end

            if (sendout) begin
                sample_q <= word1_ok ? word1_q[15:8] : 8'sd0;   // silence on underrun
                second_q <= !second_q;
                if (second_q) begin
                    // low byte gone so the prefetched word moves up
                    word1_q  <= capture ? word_i : word0_q;
                    word1_ok <= capture || word0_ok;
                    word0_ok <= 1'b0;
                end else begin
                    word1_q <= {word1_q[7:0], 8'h00};
                end
            end

            if (!audio_enable_i) begin
                fetch_q  <= 1'b0;
                length_q <= '0;         // restart from start_i when enabled again
                word0_ok <= 1'b0;
                word1_ok <= 1'b0;
            end
        end
    end

    always_comb begin
        prod_l = mul_sample_q * mul_vol_l_q;
        prod_r = mul_sample_q * mul_vol_r_q;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mix_state    <= MIX_LOAD;
            mul_sample_q <= '0;
            mul_vol_l_q  <= '0;
            mul_vol_r_q  <= '0;
            level_l_q    <= '0;
            level_r_q    <= '0;
        end else begin
            case (mix_state)
                MIX_LOAD: begin
                    mul_sample_q <= sample_q;
                    mul_vol_l_q  <= {1'b0, vol_i.left[7:1]};    // 7 bit unsigned volume
                    mul_vol_r_q  <= {1'b0, vol_i.right[7:1]};
                    mix_state    <= MIX_STORE;
                end
                MIX_STORE: begin
                    level_l_q <= {~prod_l[13], prod_l[12:6]};   // offset binary for the DAC
                    level_r_q <= {~prod_r[13], prod_r[12:6]};
                    mix_state <= MIX_LOAD;
                end
            endcase

            if (!audio_enable_i) begin
                level_l_q <= vol_i.left;        // volume word drives the DACs directly
                level_r_q <= vol_i.right;
            end
        end
    end

    assign fetch_o   = fetch_q;
    assign addr_o    = addr_q;
    assign reload_o  = reload_q && audio_enable_i;
    assign level_l_o = level_l_q;
    assign level_r_o = level_r_q;

    // fetch is never raised while disabled and drops one cycle after disabling
    assert property (@(posedge clk) disable iff (reset_i)
                     fetch_o |-> audio_enable_i || $past(audio_enable_i))
        else $error("fetch pending while audio is disabled");

    assert property (@(posedge clk) disable iff (reset_i) reload_o |=> !reload_o)
        else $error("reload strobe longer than one cycle");

endmodule

//--- source/sample_ram.sv
// word-wide sample memory with host write port and registered audio read port
`include "audio_settings.svh"

module sample_ram (
    input  logic           clk,
    input  logic           wr_i,
    input  mem_pkg::addr_t wr_addr_i,
    input  mem_pkg::word_t wr_data_i,
    input  mem_pkg::addr_t rd_addr_i,
    output mem_pkg::word_t rd_data_o
);
    import mem_pkg::*;

    localparam int AW = $clog2(`SAMPLE_RAM_WORDS);

    word_t          mem [`SAMPLE_RAM_WORDS];
    logic [AW-1:0]  wr_index;
    logic [AW-1:0]  rd_index;
    word_t          rd_data_q;

    assign wr_index = wr_addr_i[AW-1:0];        // upper address bits ignored
    assign rd_index = rd_addr_i[AW-1:0];

    always_ff @(posedge clk) begin
        if (wr_i) begin
            mem[wr_index] <= wr_data_i;
        end
    end

    // read data valid one cycle after the address
    always_ff @(posedge clk) begin
        rd_data_q <= mem[rd_index];
    end

    assign rd_data_o = rd_data_q;

endmodule

//--- source/audio_regs.sv
// channel register block with host write decode, readback and restart self-clear
`include "audio_settings.svh"

module audio_regs (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  enable_i,
    input  logic                  reg_wr_i,
    input  audio_pkg::audio_reg_e reg_addr_i,
    input  mem_pkg::word_t        reg_data_i,
    output mem_pkg::word_t        reg_rdata_o,
    input  logic                  reload_i,
    output logic                  audio_enable_o,
    output audio_pkg::audio_vol_t vol_o,
    output mem_pkg::word_t        period_o,
    output mem_pkg::addr_t        start_o,
    output audio_pkg::audio_len_u len_o
);
    import mem_pkg::*;
    import audio_pkg::*;

    word_t regs_q [`AUDIO_REG_COUNT];   // indexed by audio_reg_e
    logic  enable_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            enable_q <= 1'b0;
            for (int i = 0; i < `AUDIO_REG_COUNT; i++) begin
                regs_q[i] <= '0;                    // also clears the restart bit
            end
        end else begin
            enable_q <= enable_i;
            if (reload_i) begin
                regs_q[AUD_LEN][15] <= 1'b0;        // mixer has taken the restart
            end
            // a host write in the same cycle overrides the clear
            if (reg_wr_i) begin
                regs_q[reg_addr_i] <= reg_data_i;
            end
        end
    end

    assign reg_rdata_o    = regs_q[reg_addr_i];    // combinational readback

    assign audio_enable_o = enable_q;
    assign vol_o          = audio_vol_t'(regs_q[AUD_VOL]);
    assign period_o       = regs_q[AUD_PERIOD];
    assign start_o        = addr_t'(regs_q[AUD_START]);
    assign len_o.raw      = regs_q[AUD_LEN];

    // the mixer only reloads while playback is running
    assert property (@(posedge clk) disable iff (reset_i) reload_i |-> audio_enable_o)
        else $error("reload strobe from mixer while audio is disabled");

endmodule

//--- source/audio_pkg.sv
// channel register index, volume struct and length/control union
package audio_pkg;

    // register index as seen on the host address lines
    typedef enum logic [1:0] {
        AUD_VOL    = 2'd0,      // left volume high byte, right volume low byte
        AUD_PERIOD = 2'd1,      // 15 bit sample period
        AUD_START  = 2'd2,      // start word address
        AUD_LEN    = 2'd3       // restart bit and 15 bit length in words
    } audio_reg_e;

    // volume word, same layout for mixing and for direct DAC levels
    typedef struct packed {
        mem_pkg::byte_t left;   // top 7 bits scale the left channel
        mem_pkg::byte_t right;  // top 7 bits scale the right channel
    } audio_vol_t;

    // decoded view of the AUD_LEN word
    typedef struct packed {
        logic        restart;   // forces a reload on the next fetch
        logic [14:0] length;    // words to play before reloading
    } audio_len_fields_t;

    // the register block stores the word raw, the mixer reads the fields
    typedef union packed {
        mem_pkg::word_t    raw;
        audio_len_fields_t f;
    } audio_len_u;

endpackage

//--- source/mem_pkg.sv
// memory word, sample address and byte types shared along the sample path
package mem_pkg;

    // one memory or register word, two signed samples high byte first
    typedef logic [15:0] word_t;

    // sample word address, wider than the memory so it can be truncated
    typedef logic [15:0] addr_t;

    // one sample byte or one unsigned DAC level
    typedef logic [7:0]  byte_t;

endpackage

//--- source/audio_settings.svh
// DAC width, sample memory depth and channel register count
`ifndef AUDIO_SETTINGS_SVH
`define AUDIO_SETTINGS_SVH

// bits per DAC level, also the sigma-delta accumulator width
`define AUDIO_DAC_WIDTH     8

// words of sample memory, two samples per word
`define SAMPLE_RAM_WORDS    256

// host-visible registers of the single channel
`define AUDIO_REG_COUNT     4

`endif
